// ==== logic/adc_channel_pkg.sv ====
/*
 * Shared types and constants for the ADC receive channel
 */
`default_nettype none

package adc_channel_pkg;

  // Converter sample width
  localparam int DATA_WIDTH = 16;

  // ********************************************************************
  // Register map, word addresses relative to the channel base
  // The channel base is the channel number times 0x10
  // ********************************************************************
  localparam logic [13:0] REG_CTRL   = 14'h000;
  localparam logic [13:0] REG_DCFILT = 14'h001;
  localparam logic [13:0] REG_STATUS = 14'h002;
  localparam logic [13:0] REG_ID     = 14'h003;

  // Consecutive mismatches to lose sync, consecutive matches to lock
  localparam int PN_OOS_COUNT = 16;

  // Feedback taps over the received bit history, bit 0 being the newest bit
  // PN9 is x^9 + x^5 + 1 and PN23 is x^23 + x^18 + 1
  localparam logic [31:0] PN9_TAPS  = 32'h0000_0110;
  localparam logic [31:0] PN23_TAPS = 32'h0042_0000;

  // One converter word with its over-range flag
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  over_range;
  } adc_sample_t;

  // Channel configuration as held by the register bank
  typedef struct packed {
    logic               channel_enable;
    logic               format_enable;
    // Clear means offset-binary input that gets converted
    logic               format_signed_in;
    logic               dcfilt_enable;
    // 0 selects PN9, 1 selects PN23, anything else turns checking off
    logic [1:0]         pn_sel;
    logic [3:0]         dcfilt_shift;
    logic signed [15:0] dcfilt_offset;
    logic [13:0]        padding;
  } chan_cfg_t;

  // Status flags, in the same bit order as the STATUS register
  typedef struct packed {
    logic pn_err;
    logic pn_oos;
    logic over_range;
  } chan_status_t;

endpackage

`default_nettype wire

// ==== logic/adc_pn_monitor.sv ====
/*
 * PN9/PN23 test pattern monitor that self-synchronises on the received words
 */
`timescale 1ns/1ps
`default_nettype none

module adc_pn_monitor (
  input  logic                        adc_clk,
  input  logic                        rst_n,
  input  adc_channel_pkg::adc_sample_t sample,
  input  logic [1:0]                  pn_sel,
  output logic                        pn_err,
  output logic                        pn_oos
);

  import adc_channel_pkg::*;

  localparam int CNT_W = $clog2(PN_OOS_COUNT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PN_OOS_COUNT - 1);

  // Last two received words with the newest word in the low half
  logic [2*DATA_WIDTH-1:0] hist_q;
  logic [DATA_WIDTH-1:0]   pred;
  logic [31:0]             taps;
  logic                    pn_en;
  logic                    match;
  logic                    oos_q;
  logic                    oos_d;
  logic [CNT_W-1:0]        cnt_q;
  logic [CNT_W-1:0]        cnt_d;

  // Runs the LFSR sixteen steps past the history so the first new bit ends up in the MSB
  function automatic logic [DATA_WIDTH-1:0] pn_predict(input logic [31:0] hist,
                                                        input logic [31:0] tap_mask);
    logic [31:0]           state;
    logic [DATA_WIDTH-1:0] word;
    logic                  nb;
    state = hist;
    word  = '0;
    for (int i = 0; i < DATA_WIDTH; i++) begin
      nb    = ^(state & tap_mask);
      state = {state[30:0], nb};
      word  = {word[DATA_WIDTH-2:0], nb};
    end
    return word;
  endfunction

  assign pn_en = (pn_sel[1] == 1'b0);
  assign taps  = (pn_sel[0] == 1'b0) ? PN9_TAPS : PN23_TAPS;
  assign pred  = pn_predict(hist_q, taps);

  // An all-zero word is the LFSR lock-up state and never counts as a match
  assign match = (sample.data == pred) && (sample.data != '0);

  // The sync FSM counts runs of matches while out of sync and of mismatches while locked
  always_comb begin
    oos_d = oos_q;
    cnt_d = '0;
    if (oos_q) begin
      if (match) begin
        cnt_d = cnt_q + 1'b1;
        if (cnt_q == CNT_LAST) begin
          oos_d = 1'b0;
          cnt_d = '0;
        end
      end
    end else if (!match) begin
      cnt_d = cnt_q + 1'b1;
      if (cnt_q == CNT_LAST) begin
        oos_d = 1'b1;
        cnt_d = '0;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    hist_q <= {hist_q[DATA_WIDTH-1:0], sample.data};
  end

  // Flags come out one cycle after the word they judge
  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      oos_q  <= 1'b1;
      cnt_q  <= '0;
      pn_oos <= 1'b0;
      pn_err <= 1'b0;
    end else if (!pn_en) begin
      // Checking off restarts the search for sync
      oos_q  <= 1'b1;
      cnt_q  <= '0;
      pn_oos <= 1'b0;
      pn_err <= 1'b0;
    end else begin
      oos_q  <= oos_d;
      cnt_q  <= cnt_d;
      pn_oos <= oos_d;
      pn_err <= !oos_d && !match;
    end
  end

  // A word error is only reported while locked and never on the word that completes the lock
  assert property (@(posedge adc_clk) disable iff (!rst_n)
    pn_err |-> !pn_oos && !$past(pn_oos));

endmodule

`default_nettype wire

// ==== logic/adc_data_format.sv ====
/*
 * Offset-binary to two's-complement conversion, one register stage
 */
`timescale 1ns/1ps
`default_nettype none

module adc_data_format (
  input  logic                                adc_clk,
  input  logic                                rst_n,
  input  logic [adc_channel_pkg::DATA_WIDTH-1:0] data,
  input  adc_channel_pkg::chan_cfg_t          cfg,
  output logic [adc_channel_pkg::DATA_WIDTH-1:0] data_out
);

  import adc_channel_pkg::*;

  logic                  convert;
  logic [DATA_WIDTH-1:0] data_conv;

  // Offset binary differs from two's complement only in the sign bit
  assign convert   = cfg.format_enable && !cfg.format_signed_in;
  assign data_conv = {~data[DATA_WIDTH-1], data[DATA_WIDTH-2:0]};

  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      data_out <= '0;
    end else if (convert) begin
      data_out <= data_conv;
    end else begin
      // Bypass keeps the same one-cycle latency
      data_out <= data;
    end
  end

endmodule

`default_nettype wire

// ==== logic/adc_dc_filter.sv ====
/*
 * DC removal filter, first-order mean tracker with offset and saturation
 */
`timescale 1ns/1ps
`default_nettype none

module adc_dc_filter (
  input  logic                                adc_clk,
  input  logic                                rst_n,
  input  logic [adc_channel_pkg::DATA_WIDTH-1:0] data,
  input  adc_channel_pkg::chan_cfg_t          cfg,
  output logic [adc_channel_pkg::DATA_WIDTH-1:0] data_out
);

  import adc_channel_pkg::*;

  // The mean keeps DATA_WIDTH fraction bits below the sample's integer part
  localparam int MEAN_W  = 2 * DATA_WIDTH;
  localparam int SAT_MAX = 2**(DATA_WIDTH-1) - 1;
  localparam int SAT_MIN = -(2**(DATA_WIDTH-1));

  logic signed [MEAN_W-1:0]   mean_q;
  logic signed [MEAN_W:0]     diff;
  logic signed [MEAN_W:0]     step;
  logic [DATA_WIDTH-1:0]      d1_q;
  logic signed [DATA_WIDTH+1:0] sum;
  logic [DATA_WIDTH-1:0]      sat;

  // ********************************************************************
  // Stage 1, mean tracking
  // ********************************************************************

  // Distance from the mean to the new sample, one bit wider so it cannot wrap
  assign diff = $signed({data[DATA_WIDTH-1], data, {DATA_WIDTH{1'b0}}})
              - $signed({mean_q[MEAN_W-1], mean_q});
  assign step = diff >>> cfg.dcfilt_shift;

  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      mean_q <= '0;
      d1_q   <= '0;
    end else begin
      d1_q <= data;
      if (cfg.dcfilt_enable) begin
        mean_q <= mean_q + $signed(step[MEAN_W-1:0]);
      end else begin
        mean_q <= '0;
      end
    end
  end

  // ********************************************************************
  // Stage 2, subtract the mean, add the offset and clamp
  // ********************************************************************

  // The mean here already includes the sample that sits in d1_q
  assign sum = $signed(d1_q) - $signed(mean_q[MEAN_W-1:DATA_WIDTH])
             + $signed(cfg.dcfilt_offset);

  always_comb begin
    if (sum > SAT_MAX) begin
      sat = SAT_MAX[DATA_WIDTH-1:0];
    end else if (sum < SAT_MIN) begin
      sat = SAT_MIN[DATA_WIDTH-1:0];
    end else begin
      sat = sum[DATA_WIDTH-1:0];
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      data_out <= '0;
    end else begin
      data_out <= cfg.dcfilt_enable ? sat : d1_q;
    end
  end

  // A zero shift would jump the mean straight onto each sample
  assert property (@(posedge adc_clk) disable iff (!rst_n)
    cfg.dcfilt_enable |-> (cfg.dcfilt_shift != 4'd0));

endmodule

`default_nettype wire

// ==== logic/adc_channel_regs.sv ====
/*
 * Channel register bank on the request/acknowledge processor bus
 * Holds the configuration and the sticky status flags
 */
`timescale 1ns/1ps
`default_nettype none

module adc_channel_regs #(
  parameter int CHANNEL_ID = 0
) (
  input  logic                          adc_clk,
  input  logic                          rst_n,
  input  logic                          wreq,
  input  logic [13:0]                   waddr,
  input  logic [31:0]                   wdata,
  output logic                          wack,
  input  logic                          rreq,
  input  logic [13:0]                   raddr,
  output logic [31:0]                   rdata,
  output logic                          rack,
  input  adc_channel_pkg::chan_status_t status_in,
  output adc_channel_pkg::chan_cfg_t    cfg,
  output adc_channel_pkg::chan_status_t status
);

  import adc_channel_pkg::*;

  // Absolute addresses of this channel's registers
  localparam logic [13:0] BASE        = 14'(CHANNEL_ID * 16);
  localparam logic [13:0] ADDR_CTRL   = BASE + REG_CTRL;
  localparam logic [13:0] ADDR_DCFILT = BASE + REG_DCFILT;
  localparam logic [13:0] ADDR_STATUS = BASE + REG_STATUS;
  localparam logic [13:0] ADDR_ID     = BASE + REG_ID;

  logic         wr_ctrl;
  logic         wr_dcfilt;
  logic         wr_status;
  chan_status_t status_clr;
  logic [31:0]  rd_mux;

  assign wr_ctrl    = wreq && (waddr == ADDR_CTRL);
  assign wr_dcfilt  = wreq && (waddr == ADDR_DCFILT);
  assign wr_status  = wreq && (waddr == ADDR_STATUS);
  assign status_clr = wr_status ? chan_status_t'(wdata[2:0]) : '0;

  // ********************************************************************
  // Write side
  // ********************************************************************

  // CTRL layout
  //   [0] channel_enable, [1] format_enable, [2] format_signed_in
  //   [3] dcfilt_enable, [5:4] pn_sel, [11:8] dcfilt_shift
  // DCFILT holds the signed offset in [15:0]
  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg        <= '0;
      cfg.pn_sel <= 2'b11;
    end else begin
      if (wr_ctrl) begin
        cfg.channel_enable   <= wdata[0];
        cfg.format_enable    <= wdata[1];
        cfg.format_signed_in <= wdata[2];
        cfg.dcfilt_enable    <= wdata[3];
        cfg.pn_sel           <= wdata[5:4];
        cfg.dcfilt_shift     <= wdata[11:8];
      end
      if (wr_dcfilt) begin
        cfg.dcfilt_offset <= wdata[15:0];
      end
    end
  end

  // Sticky flags where a new event beats a clear in the same cycle
  // STATUS bits are [0] over_range, [1] pn_oos, [2] pn_err
  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      status <= '0;
    end else begin
      status <= (status & ~status_clr) | status_in;
    end
  end

  // ********************************************************************
  // Read side and acknowledges
  // ********************************************************************

  always_comb begin
    case (raddr)
      ADDR_CTRL: begin
        rd_mux = {20'd0, cfg.dcfilt_shift, 2'd0, cfg.pn_sel, cfg.dcfilt_enable,
                  cfg.format_signed_in, cfg.format_enable, cfg.channel_enable};
      end
      ADDR_DCFILT: rd_mux = {16'd0, cfg.dcfilt_offset};
      ADDR_STATUS: rd_mux = {29'd0, status};
      ADDR_ID:     rd_mux = 32'(CHANNEL_ID);
      // Foreign addresses still get an answer that reads as zero
      default:     rd_mux = '0;
    endcase
  end

  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      wack  <= 1'b0;
      rack  <= 1'b0;
      rdata <= '0;
    end else begin
      wack  <= wreq;
      rack  <= rreq;
      rdata <= rreq ? rd_mux : '0;
    end
  end

  // Every write request is answered on the very next cycle and never together with a read
  assert property (@(posedge adc_clk) disable iff (!rst_n) wreq |=> wack && !rack);

endmodule

`default_nettype wire

// ==== logic/adc_channel.sv ====
/*
 * ADC receive channel, pattern check, format conversion, DC filter and registers
 */
`timescale 1ns/1ps
`default_nettype none

module adc_channel #(
  parameter int CHANNEL_ID = 0
) (
  input  logic                                adc_clk,
  input  logic                                rst_n,
  input  adc_channel_pkg::adc_sample_t        sample,
  output logic [adc_channel_pkg::DATA_WIDTH-1:0] data_out,
  output logic                                data_valid,
  output logic                                channel_enable,
  output logic                                pn_err,
  output logic                                pn_oos,
  output logic                                over_range,
  input  logic                                wreq,
  input  logic [13:0]                         waddr,
  input  logic [31:0]                         wdata,
  output logic                                wack,
  input  logic                                rreq,
  input  logic [13:0]                         raddr,
  output logic [31:0]                         rdata,
  output logic                                rack
);

  import adc_channel_pkg::*;

  chan_cfg_t             cfg;
  chan_status_t          status_in;
  chan_status_t          status;
  logic                  mon_err;
  logic                  mon_oos;
  logic [DATA_WIDTH-1:0] fmt_data;
  // One stage per register in the formatter and filter
  logic [2:0]            valid_q;

  // The monitor taps the raw words ahead of any processing
  adc_pn_monitor pn_monitor_i (
    .adc_clk (adc_clk),
    .rst_n   (rst_n),
    .sample  (sample),
    .pn_sel  (cfg.pn_sel),
    .pn_err  (mon_err),
    .pn_oos  (mon_oos)
  );

  adc_data_format data_format_i (
    .adc_clk  (adc_clk),
    .rst_n    (rst_n),
    .data     (sample.data),
    .cfg      (cfg),
    .data_out (fmt_data)
  );

  adc_dc_filter dc_filter_i (
    .adc_clk  (adc_clk),
    .rst_n    (rst_n),
    .data     (fmt_data),
    .cfg      (cfg),
    .data_out (data_out)
  );

  // Over-range goes straight to the sticky bit, no pipeline in between
  assign status_in = '{pn_err: mon_err, pn_oos: mon_oos, over_range: sample.over_range};

  adc_channel_regs #(
    .CHANNEL_ID (CHANNEL_ID)
  ) channel_regs_i (
    .adc_clk   (adc_clk),
    .rst_n     (rst_n),
    .wreq      (wreq),
    .waddr     (waddr),
    .wdata     (wdata),
    .wack      (wack),
    .rreq      (rreq),
    .raddr     (raddr),
    .rdata     (rdata),
    .rack      (rack),
    .status_in (status_in),
    .cfg       (cfg),
    .status    (status)
  );

  // Valid follows the enable through the same three register stages as the data
  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[1:0], cfg.channel_enable};
    end
  end

  assign data_valid     = valid_q[2];
  assign channel_enable = cfg.channel_enable;
  assign pn_err         = status.pn_err;
  assign pn_oos         = status.pn_oos;
  assign over_range     = status.over_range;

endmodule

`default_nettype wire

// ==== tests/adc_channel_tb.sv ====
/*
 * Testbench for the ADC receive channel with bus tasks, stimulus and reference models
 */
`timescale 1ns/1ps
`default_nettype none

module adc_channel_tb;

  import adc_channel_pkg::*;

  localparam int WAIT_LIMIT = 200;
  // Channel 2 occupies word addresses 0x20 to 0x23
  localparam logic [13:0] BASE = 14'h020;

  logic adc_clk;
  logic rst_n;
  adc_sample_t sample;
  logic [DATA_WIDTH-1:0] data_out;
  logic data_valid, channel_enable, pn_err, pn_oos, over_range;
  logic wreq, rreq, wack, rack;
  logic [13:0] waddr, raddr;
  logic [31:0] wdata, rdata;
  chan_status_t port_st;

  // Configuration as the testbench believes the DUT holds it
  chan_cfg_t cfg_m;
  longint mean_m;
  logic [DATA_WIDTH-1:0] exp_q[$];
  logic check_on;
  // Stimulus mode is 0 for zero, 1 for random, 2 for constant plus noise and 3 for clean PN9
  int mode;
  logic [15:0] base_level;
  logic [31:0] pn_state;
  logic corrupt_req, or_req;
  logic [31:0] rd;
  int n;

  adc_channel #(.CHANNEL_ID(2)) dut_i (
    .adc_clk(adc_clk), .rst_n(rst_n), .sample(sample), .data_out(data_out),
    .data_valid(data_valid), .channel_enable(channel_enable), .pn_err(pn_err),
    .pn_oos(pn_oos), .over_range(over_range), .wreq(wreq), .waddr(waddr),
    .wdata(wdata), .wack(wack), .rreq(rreq), .raddr(raddr), .rdata(rdata), .rack(rack)
  );

  assign port_st = {pn_err, pn_oos, over_range};

  always #50 adc_clk = ~adc_clk;

  // ********************************************************************
  // Failure reporting and compare tasks
  // ********************************************************************

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_data(input logic [DATA_WIDTH-1:0] act, input logic [DATA_WIDTH-1:0] exp);
    if (act !== exp) begin
      fail_run($sformatf("** Error data_out: expected 0x%04h, actual 0x%04h", exp, act));
    end
  endtask

  task automatic check_status(input chan_status_t act, input chan_status_t exp);
    if (act !== exp) begin
      fail_run($sformatf("** Error status {pn_err,pn_oos,over_range}: expected 0x%h, actual 0x%h",
                         exp, act));
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      fail_run($sformatf("** Error %s: expected 0x%08h, actual 0x%08h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      fail_run($sformatf("** Error %s: expected 0x%h, actual 0x%h", name, exp, act));
    end
  endtask

  // ********************************************************************
  // Register bus tasks
  // ********************************************************************

  task automatic write_reg(input logic [13:0] addr, input logic [31:0] data);
    int cnt;
    cnt = 0;
    @(negedge adc_clk);
    wreq = 1'b1;
    waddr = addr;
    wdata = data;
    @(negedge adc_clk);
    wreq = 1'b0;
    while (!wack) begin
      @(negedge adc_clk);
      cnt++;
      if (cnt > WAIT_LIMIT) fail_run("Timeout waiting for the write acknowledge");
    end
  endtask

  task automatic read_reg(input logic [13:0] addr, output logic [31:0] data);
    int cnt;
    cnt = 0;
    @(negedge adc_clk);
    rreq = 1'b1;
    raddr = addr;
    @(negedge adc_clk);
    rreq = 1'b0;
    while (!rack) begin
      @(negedge adc_clk);
      cnt++;
      if (cnt > WAIT_LIMIT) fail_run("Timeout waiting for the read acknowledge");
    end
    data = rdata;
  endtask

  // The shadow changes after the edge that loaded the DUT register
  task automatic write_ctrl(input logic [31:0] word);
    write_reg(BASE + REG_CTRL, word);
    cfg_m.channel_enable   = word[0];
    cfg_m.format_enable    = word[1];
    cfg_m.format_signed_in = word[2];
    cfg_m.dcfilt_enable    = word[3];
    cfg_m.pn_sel           = word[5:4];
    cfg_m.dcfilt_shift     = word[11:8];
    check_flag("channel_enable", channel_enable, word[0]);
  endtask

  task automatic write_offset(input logic [15:0] off);
    write_reg(BASE + REG_DCFILT, {16'd0, off});
    cfg_m.dcfilt_offset = off;
  endtask

  task automatic set_mode(input int m);
    @(posedge adc_clk);
    mode = m;
  endtask

  // Waits until the given bit of the status ports rises
  task automatic wait_flag(input int which, input string what);
    int cnt;
    cnt = 0;
    while (!port_st[which]) begin
      @(negedge adc_clk);
      cnt++;
      if (cnt > WAIT_LIMIT) fail_run({"Timeout waiting for ", what});
    end
  endtask

  // Lets the pipeline drain before outputs are compared again
  task automatic run_checked(input int cycles);
    repeat (4) @(posedge adc_clk);
    check_on = 1'b1;
    repeat (cycles) @(posedge adc_clk);
    check_on = 1'b0;
  endtask

  // ********************************************************************
  // Reference model
  // ********************************************************************

  // Applies format conversion, then updates the mean and adds the offset with clamping
  function automatic logic [DATA_WIDTH-1:0] ref_output(input logic [DATA_WIDTH-1:0] x);
    logic [DATA_WIDTH-1:0] y;
    longint r;
    y = (cfg_m.format_enable && !cfg_m.format_signed_in) ? (x ^ 16'h8000) : x;
    if (!cfg_m.dcfilt_enable) begin
      mean_m = 0;
      return y;
    end
    // Mean carries 16 fraction bits
    mean_m = mean_m + (((longint'($signed(y)) <<< 16) - mean_m) >>> cfg_m.dcfilt_shift);
    r = longint'($signed(y)) - (mean_m >>> 16) + longint'($signed(cfg_m.dcfilt_offset));
    if (r > 32767) r = 32767;
    if (r < -32768) r = -32768;
    return r[15:0];
  endfunction

  always @(posedge adc_clk) begin
    if (!rst_n) begin
      exp_q.delete();
      mean_m = 0;
    end else begin
      exp_q.push_back(ref_output(sample.data));
    end
  end

  // The oldest of the last three entries is the one now at data_out
  always @(negedge adc_clk) begin
    while (exp_q.size() > 3) void'(exp_q.pop_front());
    if (check_on) begin
      check_flag("data_valid", data_valid, 1'b1);
      if (exp_q.size() == 3) check_data(data_out, exp_q[0]);
    end
  end

  // Sample driver that puts out one word per falling edge
  always @(negedge adc_clk) begin
    logic [15:0] w;
    w = '0;
    case (mode)
      1: w = 16'($urandom);
      2: w = base_level + 16'($urandom_range(0, 511)) - 16'd256;
      3: begin
        for (int i = 0; i < 16; i++) begin
          // PN9 uses x^9 + x^5 + 1
          pn_state = {pn_state[30:0], pn_state[8] ^ pn_state[4]};
          w = {w[14:0], pn_state[0]};
        end
        if (corrupt_req) w = w ^ 16'h0001;
        corrupt_req = 1'b0;
      end
      default: w = '0;
    endcase
    sample.data = w;
    sample.over_range = or_req;
    or_req = 1'b0;
  end

  initial begin
    void'($urandom(32'h451a_c9b2));
    adc_clk = 1'b0;
    rst_n = 1'b0;
    sample = '0;
    wreq = 1'b0;
    rreq = 1'b0;
    waddr = '0;
    raddr = '0;
    wdata = '0;
    cfg_m = '0;
    cfg_m.pn_sel = 2'b11;
    check_on = 1'b0;
    mode = 0;
    base_level = 16'h4000;
    pn_state = 32'h0000_01a5;
    corrupt_req = 1'b0;
    or_req = 1'b0;
    repeat (8) @(posedge adc_clk);
    @(negedge adc_clk);
    rst_n = 1'b1;

    // Outputs are all inactive straight after reset
    check_flag("channel_enable", channel_enable, 1'b0);
    check_flag("data_valid", data_valid, 1'b0);
    check_status(port_st, 3'b000);

    // Reset values, readback and a foreign address
    read_reg(BASE + REG_CTRL, rd);
    check_reg("CTRL", rd, 32'h30);
    read_reg(BASE + REG_STATUS, rd);
    check_reg("STATUS", rd, 32'h0);
    read_reg(BASE + REG_ID, rd);
    check_reg("ID", rd, 32'h2);
    write_offset(16'h1234);
    read_reg(BASE + REG_DCFILT, rd);
    check_reg("DCFILT", rd, 32'h1234);
    write_ctrl(32'h335);
    read_reg(BASE + REG_CTRL, rd);
    check_reg("CTRL", rd, 32'h335);
    read_reg(14'h010, rd);
    check_reg("foreign CTRL", rd, 32'h0);

    // Passthrough, then offset-binary conversion
    write_ctrl(32'h31);
    set_mode(1);
    run_checked(40);
    write_ctrl(32'h33);
    run_checked(40);

    // The DC filter is entered with plain zero data and then driven into both saturation limits
    set_mode(0);
    write_ctrl(32'h31);
    write_offset(16'h7000);
    write_ctrl(32'h439);
    set_mode(2);
    run_checked(200);
    write_offset(16'h8000);
    run_checked(100);
    set_mode(0);
    write_ctrl(32'h31);

    // PN9 lock, one corrupted word, then PN23 on random data
    write_ctrl(32'h01);
    set_mode(3);
    n = 0;
    rd = 32'h2;
    while (rd[1]) begin
      write_reg(BASE + REG_STATUS, 32'h7);
      repeat (2) @(posedge adc_clk);
      read_reg(BASE + REG_STATUS, rd);
      n++;
      if (n > 20) fail_run("Timeout waiting for the monitor to lock onto PN9");
    end
    check_status(port_st, 3'b000);
    @(posedge adc_clk);
    corrupt_req = 1'b1;
    wait_flag(2, "pn_err after a corrupted word");
    check_status(port_st, 3'b100);
    read_reg(BASE + REG_STATUS, rd);
    check_reg("STATUS", rd, 32'h4);
    write_ctrl(32'h11);
    set_mode(1);
    write_reg(BASE + REG_STATUS, 32'h7);
    wait_flag(1, "pn_oos on random data with PN23");

    // Over-range and write-one-to-clear
    write_ctrl(32'h31);
    set_mode(0);
    write_reg(BASE + REG_STATUS, 32'h7);
    check_status(port_st, 3'b000);
    @(posedge adc_clk);
    or_req = 1'b1;
    wait_flag(0, "the over_range flag");
    check_status(port_st, 3'b001);
    read_reg(BASE + REG_STATUS, rd);
    check_reg("STATUS", rd, 32'h1);
    write_reg(BASE + REG_STATUS, 32'h1);
    repeat (5) @(posedge adc_clk);
    @(negedge adc_clk);
    check_status(port_st, 3'b000);
    read_reg(BASE + REG_STATUS, rd);
    check_reg("STATUS", rd, 32'h0);

    $display("** PASS **");
    $finish;
  end

  // Backstop on the whole run
  initial begin
    #5ms;
    fail_run("Simulation time limit reached before the test finished");
  end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/adc_channel_pkg.sv
logic/adc_pn_monitor.sv
logic/adc_data_format.sv
logic/adc_dc_filter.sv
logic/adc_channel_regs.sv
logic/adc_channel.sv
tests/adc_channel_tb.sv
